// File: rtl/fetch_params.svh
// Fetch frontend parameters for widths, queue depths, reset PC and memory size
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Bundle geometry
`define FETCH_WIDTH 2
`define ILEN 32
`define PLEN 32
`define FETCH_BYTES 8

// Queue depths
`define REQ_DEPTH 4
`define INF_DEPTH 4
`define FQ_DEPTH 4

// Predictor and memory
`define BTB_ENTRIES 8
`define MEM_WORDS 256
`define MEM_LAT 2

`define EPOCH_W 3

// First fetch address after reset
`define RESET_PC 32'h80000000

`endif

// File: rtl/fetch_pkg.sv
// Fetch frontend types shared by the predictor, controller, memory and fetch queue
`include "fetch_params.svh"

package fetch_pkg;

  typedef logic [`PLEN-1:0] addr_t;

  typedef logic [`ILEN-1:0] inst_t;

  // Slot 0 sits in the low bits
  typedef logic [`FETCH_WIDTH-1:0][`ILEN-1:0] bundle_t;

  typedef logic [`FETCH_WIDTH-1:0] slot_mask_t;

  typedef logic [$clog2(`FETCH_WIDTH)-1:0] slot_idx_t;

  typedef logic [`EPOCH_W-1:0] epoch_t;

  // Predicted next PC per slot
  typedef addr_t [`FETCH_WIDTH-1:0] npc_vec_t;

endpackage

// File: rtl/btb_pred.sv
// Branch target buffer that predicts the next fetch PC and the taken slot of a bundle
`timescale 1ns/100ps
`include "fetch_params.svh"

module btb_pred (
  input  logic                 clk,
  input  logic                 rst,
  input  fetch_pkg::addr_t     query_pc_i,
  input  logic                 upd_valid_i,
  input  fetch_pkg::addr_t     upd_pc_i,
  input  fetch_pkg::slot_idx_t upd_slot_i,
  input  fetch_pkg::addr_t     upd_target_i,
  output logic                 pred_hit_o,
  output fetch_pkg::slot_idx_t pred_slot_o,
  output fetch_pkg::addr_t     pred_target_o,
  output fetch_pkg::addr_t     next_pc_o
);

  localparam int OFF_W = $clog2(`FETCH_BYTES);
  localparam int IDX_W = $clog2(`BTB_ENTRIES);
  localparam int TAG_W = `PLEN - OFF_W - IDX_W;

  logic [`BTB_ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]        tag_q [`BTB_ENTRIES];
  fetch_pkg::slot_idx_t    slot_q [`BTB_ENTRIES];
  fetch_pkg::addr_t        target_q [`BTB_ENTRIES];

  logic [IDX_W-1:0] q_idx;
  logic [TAG_W-1:0] q_tag;
  logic [IDX_W-1:0] u_idx;
  logic [TAG_W-1:0] u_tag;
  logic             hit;

  // Index sits just above the bundle offset, tag takes the rest
  assign q_idx = query_pc_i[OFF_W +: IDX_W];
  assign q_tag = query_pc_i[`PLEN-1 -: TAG_W];
  assign u_idx = upd_pc_i[OFF_W +: IDX_W];
  assign u_tag = upd_pc_i[`PLEN-1 -: TAG_W];

  assign hit = valid_q[q_idx] && (tag_q[q_idx] == q_tag);

  assign pred_hit_o    = hit;
  assign pred_slot_o   = hit ? slot_q[q_idx] : '0;
  assign pred_target_o = hit ? target_q[q_idx] : '0;

  // Fall through to the next sequential bundle on a miss
  assign next_pc_o = hit ? target_q[q_idx]
                         : query_pc_i + fetch_pkg::addr_t'(`FETCH_BYTES);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[u_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_valid_i) begin
      tag_q[u_idx]    <= u_tag;
      slot_q[u_idx]   <= upd_slot_i;
      target_q[u_idx] <= upd_target_i;
    end
  end

endmodule

// File: rtl/fetch_ctrl.sv
// Fetch controller with pending and in-flight request queues, epochs and slot mask building
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           redirect_valid_i,
  input  fetch_pkg::addr_t               redirect_pc_i,
  output fetch_pkg::addr_t               query_pc_o,
  input  logic                           pred_hit_i,
  input  fetch_pkg::slot_idx_t           pred_slot_i,
  input  fetch_pkg::addr_t               pred_target_i,
  input  fetch_pkg::addr_t               next_pc_i,
  output logic                           req_valid_o,
  output fetch_pkg::addr_t               req_addr_o,
  input  logic                           rsp_valid_i,
  input  fetch_pkg::bundle_t             rsp_data_i,
  input  logic [$clog2(`FQ_DEPTH+1)-1:0] fq_count_i,
  output logic                           enq_valid_o,
  output fetch_pkg::addr_t               enq_pc_o,
  output fetch_pkg::bundle_t             enq_data_o,
  output fetch_pkg::slot_mask_t          enq_mask_o,
  output fetch_pkg::npc_vec_t            enq_npc_o
);

  localparam int REQ_PTR_W  = $clog2(`REQ_DEPTH);
  localparam int REQ_CNT_W  = $clog2(`REQ_DEPTH + 1);
  localparam int INF_PTR_W  = $clog2(`INF_DEPTH);
  localparam int INF_CNT_W  = $clog2(`INF_DEPTH + 1);
  localparam int FQ_CNT_W   = $clog2(`FQ_DEPTH + 1);
  localparam int INST_BYTES = `ILEN / 8;
  localparam int DRAIN_W    = $clog2(`MEM_LAT + 1);

  typedef enum logic {
    ST_RUN,
    ST_DRAIN
  } state_e;

  state_e             state_q;
  logic [DRAIN_W-1:0] drain_cnt_q;
  fetch_pkg::addr_t   pc_q;
  fetch_pkg::epoch_t  epoch_q;

  // Pending queue of predicted requests
  fetch_pkg::addr_t     req_pc_q [`REQ_DEPTH];
  logic                 req_hit_q [`REQ_DEPTH];
  fetch_pkg::slot_idx_t req_slot_q [`REQ_DEPTH];
  fetch_pkg::addr_t     req_target_q [`REQ_DEPTH];
  logic [REQ_PTR_W-1:0] req_head_q;
  logic [REQ_PTR_W-1:0] req_tail_q;
  logic [REQ_CNT_W-1:0] req_count_q;

  // In-flight queue of issued requests
  fetch_pkg::addr_t     inf_pc_q [`INF_DEPTH];
  logic                 inf_hit_q [`INF_DEPTH];
  fetch_pkg::slot_idx_t inf_slot_q [`INF_DEPTH];
  fetch_pkg::addr_t     inf_target_q [`INF_DEPTH];
  fetch_pkg::epoch_t    inf_epoch_q [`INF_DEPTH];
  logic [INF_PTR_W-1:0] inf_head_q;
  logic [INF_PTR_W-1:0] inf_tail_q;
  logic [INF_CNT_W-1:0] inf_count_q;

  logic                 req_empty;
  logic                 req_full;
  logic                 inf_empty;
  logic                 inf_full;
  logic                 budget_ok;
  logic                 req_enq;
  logic                 req_issue;
  logic                 rsp_capture;
  logic [REQ_PTR_W-1:0] enq_idx;

  function automatic logic [REQ_PTR_W-1:0] req_ptr_inc(input logic [REQ_PTR_W-1:0] ptr);
    return (ptr == REQ_PTR_W'(`REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  function automatic logic [INF_PTR_W-1:0] inf_ptr_inc(input logic [INF_PTR_W-1:0] ptr);
    return (ptr == INF_PTR_W'(`INF_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign req_empty = (req_count_q == '0);
  assign req_full  = (req_count_q == REQ_CNT_W'(`REQ_DEPTH));
  assign inf_empty = (inf_count_q == '0);
  assign inf_full  = (inf_count_q == INF_CNT_W'(`INF_DEPTH));

  // Every in-flight request must find a fetch queue slot when it returns
  assign budget_ok = (int'(fq_count_i) + int'(inf_count_q)) < `FQ_DEPTH;

  assign query_pc_o = redirect_valid_i ? redirect_pc_i : pc_q;

  assign req_issue = !redirect_valid_i && !req_empty && !inf_full && budget_ok;
  assign req_enq   = redirect_valid_i || !req_full || req_issue;
  assign enq_idx   = redirect_valid_i ? '0 : req_tail_q;

  assign req_valid_o = req_issue;
  assign req_addr_o  = req_pc_q[req_head_q];

  assign rsp_capture = rsp_valid_i && !redirect_valid_i && !inf_empty &&
                       (inf_epoch_q[inf_head_q] == epoch_q);

  assign enq_valid_o = rsp_capture;
  assign enq_pc_o    = inf_pc_q[inf_head_q];
  assign enq_data_o  = rsp_data_i;

  // Slots past a predicted taken branch are squashed
  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      enq_mask_o[i] = 1'b1;
      enq_npc_o[i]  = inf_pc_q[inf_head_q] + fetch_pkg::addr_t'(INST_BYTES * (i + 1));
      if (inf_hit_q[inf_head_q]) begin
        if (i > int'(inf_slot_q[inf_head_q])) begin
          enq_mask_o[i] = 1'b0;
          enq_npc_o[i]  = '0;
        end else if (i == int'(inf_slot_q[inf_head_q])) begin
          enq_npc_o[i] = inf_target_q[inf_head_q];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= `RESET_PC;
      epoch_q     <= '0;
      req_head_q  <= '0;
      req_tail_q  <= '0;
      req_count_q <= '0;
      inf_head_q  <= '0;
      inf_tail_q  <= '0;
      inf_count_q <= '0;
      state_q     <= ST_RUN;
      drain_cnt_q <= '0;
    end else if (redirect_valid_i) begin
      // Restart with the redirect target as the only pending entry
      pc_q        <= next_pc_i;
      epoch_q     <= epoch_q + 1'b1;
      req_head_q  <= '0;
      req_tail_q  <= req_ptr_inc('0);
      req_count_q <= REQ_CNT_W'(1);
      inf_head_q  <= '0;
      inf_tail_q  <= '0;
      inf_count_q <= '0;
      state_q     <= ST_DRAIN;
      drain_cnt_q <= DRAIN_W'(`MEM_LAT - 1);
    end else begin
      if (req_enq) begin
        pc_q       <= next_pc_i;
        req_tail_q <= req_ptr_inc(req_tail_q);
      end
      if (req_issue) begin
        req_head_q <= req_ptr_inc(req_head_q);
        inf_tail_q <= inf_ptr_inc(inf_tail_q);
      end
      if (rsp_capture) begin
        inf_head_q <= inf_ptr_inc(inf_head_q);
      end
      req_count_q <= req_count_q + REQ_CNT_W'(req_enq) - REQ_CNT_W'(req_issue);
      inf_count_q <= inf_count_q + INF_CNT_W'(req_issue) - INF_CNT_W'(rsp_capture);
      if (state_q == ST_DRAIN) begin
        drain_cnt_q <= drain_cnt_q - 1'b1;
        if (drain_cnt_q <= DRAIN_W'(1)) begin
          state_q <= ST_RUN;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_enq) begin
      req_pc_q[enq_idx]     <= query_pc_o;
      req_hit_q[enq_idx]    <= pred_hit_i;
      req_slot_q[enq_idx]   <= pred_slot_i;
      req_target_q[enq_idx] <= pred_target_i;
    end
    if (req_issue) begin
      inf_pc_q[inf_tail_q]     <= req_pc_q[req_head_q];
      inf_hit_q[inf_tail_q]    <= req_hit_q[req_head_q];
      inf_slot_q[inf_tail_q]   <= req_slot_q[req_head_q];
      inf_target_q[inf_tail_q] <= req_target_q[req_head_q];
      inf_epoch_q[inf_tail_q]  <= epoch_q;
    end
  end

  // Budget check in this block keeps the fetch queue from overflowing
  a_capture_room: assert property (@(posedge clk) disable iff (rst)
    rsp_capture |-> (fq_count_i != FQ_CNT_W'(`FQ_DEPTH)));

  // Outside the drain window every response belongs to the current epoch and is kept
  a_run_capture: assert property (@(posedge clk) disable iff (rst)
    (state_q == ST_RUN) && rsp_valid_i && !redirect_valid_i |-> rsp_capture);

endmodule

// File: rtl/inst_mem.sv
// Instruction memory with fixed-latency pipelined bundle reads and a preload write port
`timescale 1ns/100ps
`include "fetch_params.svh"

module inst_mem (
  input  logic               clk,
  input  logic               rst,
  input  logic               wr_en_i,
  input  fetch_pkg::addr_t   wr_addr_i,
  input  fetch_pkg::inst_t   wr_data_i,
  input  logic               req_valid_i,
  input  fetch_pkg::addr_t   req_addr_i,
  output logic               rsp_valid_o,
  output fetch_pkg::bundle_t rsp_data_o
);

  localparam int IDX_W    = $clog2(`MEM_WORDS);
  localparam int WORD_OFF = $clog2(`ILEN / 8);

  fetch_pkg::inst_t   mem_q [`MEM_WORDS];
  logic [IDX_W-1:0]   wr_idx;
  logic [IDX_W-1:0]   rd_idx;
  fetch_pkg::bundle_t rd_bundle;

  // Read pipeline whose last stage drives the response
  logic [`MEM_LAT-1:0] vld_q;
  fetch_pkg::bundle_t  data_q [`MEM_LAT];

  // Word index wraps modulo the memory size
  assign wr_idx = wr_addr_i[WORD_OFF +: IDX_W];
  assign rd_idx = req_addr_i[WORD_OFF +: IDX_W];

  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      rd_bundle[i] = mem_q[rd_idx + IDX_W'(i)];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_idx] <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= req_valid_i;
      for (int s = 1; s < `MEM_LAT; s++) begin
        vld_q[s] <= vld_q[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    data_q[0] <= rd_bundle;
    for (int s = 1; s < `MEM_LAT; s++) begin
      data_q[s] <= data_q[s-1];
    end
  end

  assign rsp_valid_o = vld_q[`MEM_LAT-1];
  assign rsp_data_o  = data_q[`MEM_LAT-1];

endmodule

// File: rtl/fetch_queue.sv
// Circular fetch queue of bundles with flush and occupancy count
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_queue (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           flush_i,
  input  logic                           enq_valid_i,
  input  fetch_pkg::addr_t               enq_pc_i,
  input  fetch_pkg::bundle_t             enq_data_i,
  input  fetch_pkg::slot_mask_t          enq_mask_i,
  input  fetch_pkg::npc_vec_t            enq_npc_i,
  output logic                           deq_valid_o,
  input  logic                           deq_ready_i,
  output fetch_pkg::addr_t               deq_pc_o,
  output fetch_pkg::bundle_t             deq_data_o,
  output fetch_pkg::slot_mask_t          deq_mask_o,
  output fetch_pkg::npc_vec_t            deq_npc_o,
  output logic [$clog2(`FQ_DEPTH+1)-1:0] count_o
);

  localparam int PTR_W = $clog2(`FQ_DEPTH);
  localparam int CNT_W = $clog2(`FQ_DEPTH + 1);

  fetch_pkg::addr_t      pc_q [`FQ_DEPTH];
  fetch_pkg::bundle_t    data_q [`FQ_DEPTH];
  fetch_pkg::slot_mask_t mask_q [`FQ_DEPTH];
  fetch_pkg::npc_vec_t   npc_q [`FQ_DEPTH];
  logic [PTR_W-1:0]      head_q;
  logic [PTR_W-1:0]      tail_q;
  logic [CNT_W-1:0]      count_q;
  logic                  push;
  logic                  pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`FQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign deq_valid_o = (count_q != '0);
  assign push        = enq_valid_i;
  assign pop         = deq_valid_o && deq_ready_i;

  assign deq_pc_o   = pc_q[head_q];
  assign deq_data_o = data_q[head_q];
  assign deq_mask_o = mask_q[head_q];
  assign deq_npc_o  = npc_q[head_q];
  assign count_o    = count_q;

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        tail_q <= ptr_inc(tail_q);
      end
      if (pop) begin
        head_q <= ptr_inc(head_q);
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      pc_q[tail_q]   <= enq_pc_i;
      data_q[tail_q] <= enq_data_i;
      mask_q[tail_q] <= enq_mask_i;
      npc_q[tail_q]  <= enq_npc_i;
    end
  end

  // Upstream issue budget guarantees room for every returning bundle
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    enq_valid_i && !flush_i |-> (count_q != CNT_W'(`FQ_DEPTH)));

endmodule

// File: rtl/fetch_top.sv
// Fetch frontend top level joining predictor, controller, instruction memory and fetch queue
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  redirect_valid_i,
  input  fetch_pkg::addr_t      redirect_pc_i,
  input  logic                  btb_upd_valid_i,
  input  fetch_pkg::addr_t      btb_upd_pc_i,
  input  fetch_pkg::slot_idx_t  btb_upd_slot_i,
  input  fetch_pkg::addr_t      btb_upd_target_i,
  input  logic                  mem_wr_en_i,
  input  fetch_pkg::addr_t      mem_wr_addr_i,
  input  fetch_pkg::inst_t      mem_wr_data_i,
  output logic                  fetch_valid_o,
  input  logic                  fetch_ready_i,
  output fetch_pkg::addr_t      fetch_pc_o,
  output fetch_pkg::bundle_t    fetch_data_o,
  output fetch_pkg::slot_mask_t fetch_mask_o,
  output fetch_pkg::npc_vec_t   fetch_npc_o
);

  fetch_pkg::addr_t               query_pc;
  logic                           pred_hit;
  fetch_pkg::slot_idx_t           pred_slot;
  fetch_pkg::addr_t               pred_target;
  fetch_pkg::addr_t               next_pc;
  logic                           req_valid;
  fetch_pkg::addr_t               req_addr;
  logic                           rsp_valid;
  fetch_pkg::bundle_t             rsp_data;
  logic [$clog2(`FQ_DEPTH+1)-1:0] fq_count;
  logic                           enq_valid;
  fetch_pkg::addr_t               enq_pc;
  fetch_pkg::bundle_t             enq_data;
  fetch_pkg::slot_mask_t          enq_mask;
  fetch_pkg::npc_vec_t            enq_npc;

  btb_pred u_btb (
    .clk           (clk),
    .rst           (rst),
    .query_pc_i    (query_pc),
    .upd_valid_i   (btb_upd_valid_i),
    .upd_pc_i      (btb_upd_pc_i),
    .upd_slot_i    (btb_upd_slot_i),
    .upd_target_i  (btb_upd_target_i),
    .pred_hit_o    (pred_hit),
    .pred_slot_o   (pred_slot),
    .pred_target_o (pred_target),
    .next_pc_o     (next_pc)
  );

  fetch_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .query_pc_o       (query_pc),
    .pred_hit_i       (pred_hit),
    .pred_slot_i      (pred_slot),
    .pred_target_i    (pred_target),
    .next_pc_i        (next_pc),
    .req_valid_o      (req_valid),
    .req_addr_o       (req_addr),
    .rsp_valid_i      (rsp_valid),
    .rsp_data_i       (rsp_data),
    .fq_count_i       (fq_count),
    .enq_valid_o      (enq_valid),
    .enq_pc_o         (enq_pc),
    .enq_data_o       (enq_data),
    .enq_mask_o       (enq_mask),
    .enq_npc_o        (enq_npc)
  );

  inst_mem u_mem (
    .clk         (clk),
    .rst         (rst),
    .wr_en_i     (mem_wr_en_i),
    .wr_addr_i   (mem_wr_addr_i),
    .wr_data_i   (mem_wr_data_i),
    .req_valid_i (req_valid),
    .req_addr_i  (req_addr),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data)
  );

  // Redirect also empties the fetch queue
  fetch_queue u_fq (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (redirect_valid_i),
    .enq_valid_i (enq_valid),
    .enq_pc_i    (enq_pc),
    .enq_data_i  (enq_data),
    .enq_mask_i  (enq_mask),
    .enq_npc_i   (enq_npc),
    .deq_valid_o (fetch_valid_o),
    .deq_ready_i (fetch_ready_i),
    .deq_pc_o    (fetch_pc_o),
    .deq_data_o  (fetch_data_o),
    .deq_mask_o  (fetch_mask_o),
    .deq_npc_o   (fetch_npc_o),
    .count_o     (fq_count)
  );

endmodule

// File: test/fetch_tests.svh
// Directed fetch frontend tests for reset, back-pressure, branches, redirects and random ready

localparam fetch_pkg::addr_t BR_START   = 32'h8000_0100;
localparam fetch_pkg::addr_t BR_PC      = 32'h8000_0110;
localparam fetch_pkg::addr_t BR_TARGET  = 32'h8000_0200;
localparam fetch_pkg::addr_t OLD_PATH   = 32'h8000_0500;
localparam fetch_pkg::addr_t NEW_PATH   = 32'h8000_0400;
localparam fetch_pkg::addr_t LOOP_START = 32'h8000_0300;
localparam fetch_pkg::addr_t LOOP_BR    = 32'h8000_0318;

task automatic redirect_to(input fetch_pkg::addr_t pc);
  tick();
  redirect_valid_i = 1'b1;
  redirect_pc_i    = pc;
  fetch_ready_i    = 1'b0;
  exp_pc           = pc;
  tick();
  redirect_valid_i = 1'b0;
endtask

task automatic btb_write(input fetch_pkg::addr_t pc, input fetch_pkg::slot_idx_t slot,
                         input fetch_pkg::addr_t target);
  logic [IDX_W-1:0] idx;
  idx = pc[OFF_W +: IDX_W];
  tick();
  btb_upd_valid_i  = 1'b1;
  btb_upd_pc_i     = pc;
  btb_upd_slot_i   = slot;
  btb_upd_target_i = target;
  fetch_ready_i    = 1'b0;
  ref_btb_valid[idx]  = 1'b1;
  ref_btb_pc[idx]     = pc;
  ref_btb_slot[idx]   = slot;
  ref_btb_target[idx] = target;
  tick();
  btb_upd_valid_i = 1'b0;
endtask

task automatic wait_valid();
  int waited;
  waited = 0;
  while (!fetch_valid_o) begin
    tick();
    waited++;
    if (waited > 100) begin
      abort("fetch_valid_o never went high while waiting for a bundle");
    end
  end
endtask

// A bundle checked here is taken at the next rising edge
task automatic run_consumer(input int max_bundles, input int max_cycles, input bit rand_ready,
                            output int consumed);
  int cycles;
  bit r;
  consumed = 0;
  cycles   = 0;
  while (consumed < max_bundles && cycles < max_cycles) begin
    tick();
    r = rand_ready ? 1'($urandom % 2) : 1'b1;
    fetch_ready_i = r;
    if (fetch_valid_o && r) begin
      check_bundle();
      consumed++;
    end
    cycles++;
  end
  tick();
  fetch_ready_i = 1'b0;
endtask

task automatic consume_n(input int n);
  int got;
  run_consumer(n, 200, 1'b0, got);
  if (got != n) begin
    abort("fetch bundles stopped arriving before the expected count");
  end
endtask

task automatic reset_then_sequential();
  $display("Reset and sequential fetch");
  check_equal(fetch_valid_o, 1'b0, "fetch_valid_o after reset");
  check_equal(dut_i.req_valid, 1'b0, "memory request after reset");
  consume_n(8);
endtask

task automatic stall_and_release();
  fetch_pkg::addr_t      snap_pc;
  fetch_pkg::bundle_t    snap_data;
  fetch_pkg::slot_mask_t snap_mask;
  fetch_pkg::npc_vec_t   snap_npc;
  $display("Back-pressure stall");
  fetch_ready_i = 1'b0;
  wait_valid();
  snap_pc   = fetch_pc_o;
  snap_data = fetch_data_o;
  snap_mask = fetch_mask_o;
  snap_npc  = fetch_npc_o;
  repeat (50) begin
    tick();
    fetch_ready_i = 1'b0;
    check_equal(fetch_valid_o, 1'b1, "fetch_valid_o during stall");
    check_equal(fetch_pc_o, snap_pc, "pc during stall");
    check_equal(fetch_data_o, snap_data, "data during stall");
    check_equal(fetch_mask_o, snap_mask, "mask during stall");
    check_equal(fetch_npc_o, snap_npc, "npc during stall");
  end
  consume_n(12);
endtask

task automatic follow_taken_branch();
  $display("Taken branch in slot 0");
  btb_write(BR_PC, 1'b0, BR_TARGET);
  redirect_to(BR_START);
  consume_n(3);
  check_equal(last_pc, BR_PC, "branch bundle pc");
  check_equal(last_mask, 2'b01, "branch bundle mask");
  check_equal(last_npc[0], BR_TARGET, "branch bundle slot 0 npc");
  consume_n(1);
  check_equal(last_pc, BR_TARGET, "bundle after taken branch");
endtask

task automatic flush_on_redirect();
  $display("Redirect with work in flight");
  redirect_to(OLD_PATH);
  // Old-path bundles sit queued while more are still in the memory pipe
  wait_valid();
  redirect_to(NEW_PATH);
  consume_n(10);
endtask

task automatic consume_with_random_ready();
  int got;
  $display("Random ready on a BTB loop");
  btb_write(LOOP_BR, 1'b1, LOOP_START);
  redirect_to(LOOP_START);
  run_consumer(1000000, 300, 1'b1, got);
  check_equal(got != 0, 1'b1, "bundles consumed under random ready");
endtask

// File: test/tb_fetch.sv
// Testbench for the fetch frontend with a reference path model and directed tests
`timescale 1ns/100ps
`include "fetch_params.svh"

module tb_fetch;

  localparam int MAX_CYCLES = 4000;
  localparam int OFF_W      = $clog2(`FETCH_BYTES);
  localparam int IDX_W      = $clog2(`BTB_ENTRIES);
  localparam int INST_BYTES = `ILEN / 8;

  logic                  clk;
  logic                  rst;
  logic                  redirect_valid_i;
  fetch_pkg::addr_t      redirect_pc_i;
  logic                  btb_upd_valid_i;
  fetch_pkg::addr_t      btb_upd_pc_i;
  fetch_pkg::slot_idx_t  btb_upd_slot_i;
  fetch_pkg::addr_t      btb_upd_target_i;
  logic                  mem_wr_en_i;
  fetch_pkg::addr_t      mem_wr_addr_i;
  fetch_pkg::inst_t      mem_wr_data_i;
  logic                  fetch_valid_o;
  logic                  fetch_ready_i;
  fetch_pkg::addr_t      fetch_pc_o;
  fetch_pkg::bundle_t    fetch_data_o;
  fetch_pkg::slot_mask_t fetch_mask_o;
  fetch_pkg::npc_vec_t   fetch_npc_o;

  // Expected path and a copy of the BTB contents for the reference model
  fetch_pkg::addr_t      exp_pc;
  bit                    ref_btb_valid [`BTB_ENTRIES];
  fetch_pkg::addr_t      ref_btb_pc [`BTB_ENTRIES];
  fetch_pkg::slot_idx_t  ref_btb_slot [`BTB_ENTRIES];
  fetch_pkg::addr_t      ref_btb_target [`BTB_ENTRIES];

  // Last consumed bundle
  fetch_pkg::addr_t      last_pc;
  fetch_pkg::slot_mask_t last_mask;
  fetch_pkg::npc_vec_t   last_npc;

  int cycle_count = 0;
  int fail_count = 0;

  fetch_top dut_i (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .btb_upd_valid_i  (btb_upd_valid_i),
    .btb_upd_pc_i     (btb_upd_pc_i),
    .btb_upd_slot_i   (btb_upd_slot_i),
    .btb_upd_target_i (btb_upd_target_i),
    .mem_wr_en_i      (mem_wr_en_i),
    .mem_wr_addr_i    (mem_wr_addr_i),
    .mem_wr_data_i    (mem_wr_data_i),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_ready_i    (fetch_ready_i),
    .fetch_pc_o       (fetch_pc_o),
    .fetch_data_o     (fetch_data_o),
    .fetch_mask_o     (fetch_mask_o),
    .fetch_npc_o      (fetch_npc_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      abort("Timeout: the run did not finish within the cycle limit");
    end
  end

  // Inputs change and outputs are read 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic abort(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // Word k of the preload holds A5000000 plus k
  function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t a);
    int unsigned k;
    k = (a / INST_BYTES) % `MEM_WORDS;
    return 32'hA500_0000 + k;
  endfunction

  task automatic preload_mem();
    for (int k = 0; k < `MEM_WORDS; k++) begin
      tick();
      mem_wr_en_i   = 1'b1;
      mem_wr_addr_i = fetch_pkg::addr_t'(k * INST_BYTES);
      mem_wr_data_i = 32'hA500_0000 + k;
    end
    tick();
    mem_wr_en_i = 1'b0;
  endtask

  // Compare the head bundle with the reference path, then step the path
  task automatic check_bundle();
    fetch_pkg::addr_t      pc;
    fetch_pkg::bundle_t    exp_data;
    fetch_pkg::slot_mask_t exp_mask;
    fetch_pkg::npc_vec_t   exp_npc;
    logic [IDX_W-1:0]      idx;
    logic                  hit;
    pc  = exp_pc;
    idx = pc[OFF_W +: IDX_W];
    hit = ref_btb_valid[idx] && (ref_btb_pc[idx][`PLEN-1:OFF_W] == pc[`PLEN-1:OFF_W]);
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      exp_data[i] = mem_word(pc + fetch_pkg::addr_t'(INST_BYTES * i));
      exp_mask[i] = 1'b1;
      exp_npc[i]  = pc + fetch_pkg::addr_t'(INST_BYTES * (i + 1));
      if (hit && i > int'(ref_btb_slot[idx])) begin
        exp_mask[i] = 1'b0;
        exp_npc[i]  = '0;
      end else if (hit && i == int'(ref_btb_slot[idx])) begin
        exp_npc[i] = ref_btb_target[idx];
      end
    end
    check_equal(fetch_pc_o, pc, "bundle pc");
    check_equal(fetch_data_o, exp_data, "bundle data");
    check_equal(fetch_mask_o, exp_mask, "bundle slot mask");
    check_equal(fetch_npc_o, exp_npc, "bundle next pc vector");
    last_pc   = fetch_pc_o;
    last_mask = fetch_mask_o;
    last_npc  = fetch_npc_o;
    exp_pc    = hit ? ref_btb_target[idx] : pc + fetch_pkg::addr_t'(`FETCH_BYTES);
  endtask

  `include "fetch_tests.svh"

  initial begin
    void'($urandom(97391));
    rst              = 1'b1;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    btb_upd_valid_i  = 1'b0;
    btb_upd_pc_i     = '0;
    btb_upd_slot_i   = '0;
    btb_upd_target_i = '0;
    mem_wr_en_i      = 1'b0;
    mem_wr_addr_i    = '0;
    mem_wr_data_i    = '0;
    fetch_ready_i    = 1'b0;
    exp_pc           = `RESET_PC;
    for (int e = 0; e < `BTB_ENTRIES; e++) begin
      ref_btb_valid[e] = 1'b0;
    end
    // Memory is filled while the core is held in reset
    preload_mem();
    repeat (16) tick();
    rst = 1'b0;

    reset_then_sequential();
    stall_and_release();
    follow_taken_branch();
    flush_on_redirect();
    consume_with_random_ready();

    if (fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+rtl
+incdir+test
rtl/fetch_pkg.sv
rtl/btb_pred.sv
rtl/fetch_ctrl.sv
rtl/inst_mem.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
test/tb_fetch.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_fetch
FILELIST  := src.f

MDIR := obj_dir
BIN  := $(MDIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard rtl/*.svh test/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(MDIR)
